/* run_sim.sh */
#!/usr/bin/env bash
# build and run the zports testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f zports.f --top-module tb_zports -o tb_zports
./obj_dir/tb_zports | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* source/config_regs.sv */
/*
 * xxBF configuration, border colour and breakpoint address
 * plus beeper, covox and nmi clear strobes
 */
`default_nettype none

module config_regs (
	input  logic                     fclk,
	input  logic                     rst_n,
	input  zports_pkg::port_access_t acc,
	output zports_pkg::config_t      cfg,
	output logic [3:0]               border,
	output logic [15:0]              brk_addr,
	output logic                     beeper_wr,
	output logic                     covox_wr,
	output logic                     clr_nmi
);
	import zports_pkg::*;

	bd_sel_e bd_sel;

	assign bd_sel = bd_sel_e'(acc.addr_hi[4:0]); // a[12:8]

	always_ff @(posedge fclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			cfg      <= '0;
			border   <= 4'h0;
			brk_addr <= 16'h0000;
		end
		else if (acc.wr)
		begin
			if (acc.kind == PK_BF)
				cfg <= config_t'(acc.data[5:0]);
			if (acc.kind == PK_FE || acc.kind == PK_F6FC)
				border <= {~acc.lo_a3, acc.data[2:0]}; // a3 low gives bright
			if (acc.kind == PK_BD)
			begin
				// a8 picks the byte
				if (bd_sel == BD_LOBRK)
					brk_addr[7:0] <= acc.data;
				else if (bd_sel == BD_HIBRK)
					brk_addr[15:8] <= acc.data;
			end
		end
	end

	assign beeper_wr = acc.wr && acc.kind == PK_FE; // not on F6/FC
	assign covox_wr  = acc.wr && acc.kind == PK_COVOX;
	assign clr_nmi   = acc.wr && acc.kind == PK_BE;

endmodule

`default_nettype wire

/* source/io_strobe_sync.sv */
/*
 * Z80 I/O request sampler, makes one-cycle fclk read and write strobes
 */
`default_nettype none

module io_strobe_sync (
	input  logic fclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic wr_stb,
	output logic rd_stb
);

	logic [1:0] wr_hist; // [0] newest sample
	logic [1:0] rd_hist;

	always_ff @(posedge fclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_hist <= 2'b00;
			rd_hist <= 2'b00;
			wr_stb  <= 1'b0;
			rd_stb  <= 1'b0;
		end
		else
		begin
			wr_hist <= {wr_hist[0], ~(iorq_n | wr_n)};
			rd_hist <= {rd_hist[0], ~(iorq_n | rd_n)};
			wr_stb  <= wr_hist[0] & ~wr_hist[1]; // rising edge of request
			rd_stb  <= rd_hist[0] & ~rd_hist[1];
		end
	end

endmodule

`default_nettype wire

/* source/paging_regs.sv */
/*
 * 7FFD and EFF7 memory paging registers with 1M lock and derived page outputs
 */
`default_nettype none

module paging_regs (
	input  logic                     fclk,
	input  logic                     rst_n,
	input  zports_pkg::port_access_t acc,
	output zports_pkg::paging_t      paging
);
	import zports_pkg::*;

	logic [7:0] p7ffd_q; // 2..0 page, 3 screen, 4 rom, 5 lock48, 7..6 high page
	logic [7:0] peff7_q; // 0 p16c, 2 block1m, 3 ram0, 4 turbo off
	logic       block1m;
	logic       block7ffd;

	assign block1m   = peff7_q[2];
	assign block7ffd = p7ffd_q[5] & block1m; // 48k lock only in 128k mode

	always_ff @(posedge fclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_q <= 8'h00;
			peff7_q <= 8'h00;
		end
		else if (acc.wr)
		begin
			if (acc.kind == PK_7FFD && !block7ffd)
				p7ffd_q <= acc.data;
			if (acc.kind == PK_EFF7)
				peff7_q <= acc.data;
		end
	end

	////////////////////////////////////////////////////////////
	// derived outputs
	////////////////////////////////////////////////////////////
	always_comb
	begin
		paging.p7ffd     = {(block1m ? 3'b000 : p7ffd_q[7:5]), p7ffd_q[4:0]};
		paging.peff7     = block1m ? (peff7_q & 8'b1011_0001) : peff7_q; // keep 7,5,4,0
		paging.p7ffd_raw = p7ffd_q;
		paging.peff7_raw = peff7_q;

		paging.pent1m_page   = {p7ffd_q[7:5], p7ffd_q[2:0]};
		paging.pent1m_rom    = p7ffd_q[4];
		paging.pent1m_1m_on  = ~block1m;
		paging.pent1m_ram0_0 = peff7_q[3];
	end

endmodule

`default_nettype wire

/* source/port_decoder.sv */
/*
 * low address byte decoder
 * resolves shadow aliasing into a port kind, flags internal and external hits
 */
`default_nettype none

module port_decoder (
	input  logic [15:0]            addr,
	input  logic                   dos,
	input  logic                   shadow_en,
	output zports_pkg::port_kind_e port_kind,
	output logic                   porthit,
	output logic                   external_port
);
	import zports_pkg::*;

	logic       shadow;
	logic [7:0] loa;

	assign shadow = dos | shadow_en;
	assign loa    = addr[7:0];

	always_comb
	begin
		port_kind = PK_NONE;
		porthit   = 1'b1; // most listed ports hit
		case (loa)
			PORT_FE: port_kind = PK_FE;
			PORT_F6: port_kind = PK_F6FC;
			PORT_FC: port_kind = addr[15] ? PK_F6FC : PK_7FFD;
			PORT_FD: port_kind = addr[15] ? PK_NONE : PK_7FFD; // BFFD/FFFD go outside
			PORT_F7:
			begin
				// shadow form xEF7 never reaches the register
				if (!shadow && addr[8] && !addr[12])
					port_kind = PK_EFF7;
				porthit = !shadow;
			end
			PORT_BF: port_kind = PK_BF;
			PORT_BE: port_kind = PK_BE;
			PORT_BD: port_kind = PK_BD;
			PORT_3B: port_kind = addr[14] ? PK_UP_DATA : PK_UP_REG;
			PORT_FB:
			begin
				port_kind = PK_COVOX;
				porthit   = 1'b0; // write-only, bus left to others
			end
			default: porthit = 1'b0;
		endcase
	end

	// AY register/data ports
	assign external_port = (loa == PORT_FD) && addr[15];

endmodule

`default_nettype wire

/* source/read_mux.sv */
/*
 * read data selection for the internal ports and xxBD/xxBE readback
 */
`default_nettype none

module read_mux (
	input  logic [15:0]            addr,
	input  zports_pkg::port_kind_e port_kind,
	input  zports_pkg::paging_t    paging,
	input  zports_pkg::config_t    cfg,
	input  logic [3:0]             border,
	input  logic [15:0]            brk_addr,
	input  logic [7:0]             up_lastwritten,
	input  logic [4:0]             keys_in,
	input  logic                   tape_read,
	output logic [7:0]             dout
);
	import zports_pkg::*;

	bd_sel_e    bd_sel;
	logic [7:0] bd_data;
	logic [7:0] fe_data;

	assign bd_sel  = bd_sel_e'(addr[12:8]);
	assign fe_data = {1'b1, tape_read, 1'b0, keys_in};

	// register readback, raw values
	always_comb
	begin
		case (bd_sel)
			BD_P7FFD:  bd_data = paging.p7ffd_raw;
			BD_PEFF7:  bd_data = paging.peff7_raw;
			BD_BORDER: bd_data = {4'h0, border};
			BD_LOBRK:  bd_data = brk_addr[7:0];
			BD_HIBRK:  bd_data = brk_addr[15:8];
			default:   bd_data = 8'hFF;
		endcase
	end

	always_comb
	begin
		case (port_kind)
			PK_FE:                 dout = fe_data;
			PK_F6FC:               dout = (addr[7:0] == PORT_F6) ? fe_data : 8'hFF; // FC floats
			PK_BF:                 dout = {2'b00, cfg};
			PK_BD, PK_BE:          dout = bd_data;
			PK_UP_REG, PK_UP_DATA: dout = up_lastwritten;
			default:               dout = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

/* source/ulaplus_ctrl.sv */
/*
 * ULAplus controller, register port selects palette or mode group
 */
`default_nettype none

module ulaplus_ctrl (
	input  logic                     fclk,
	input  logic                     rst_n,
	input  zports_pkg::port_access_t acc,
	output logic                     up_ena,
	output logic [5:0]               up_paladdr,
	output logic [7:0]               up_paldata,
	output logic                     up_palwr,
	output logic [7:0]               up_lastwritten
);
	import zports_pkg::*;

	up_state_e state;
	logic      reg_wr;
	logic      data_wr;

	assign reg_wr  = acc.wr && acc.kind == PK_UP_REG;  // BF3B
	assign data_wr = acc.wr && acc.kind == PK_UP_DATA; // FF3B

	////////////////////////////////////////////////////////////
	// group select FSM and enable
	////////////////////////////////////////////////////////////
	always_ff @(posedge fclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			state  <= UP_PALETTE;
			up_ena <= 1'b0;
		end
		else
		begin
			if (reg_wr && acc.data[7:6] == 2'b01)
				state <= UP_MODE;
			else if (reg_wr && acc.data[7:6] == 2'b00)
				state <= UP_PALETTE;

			if (data_wr && state == UP_MODE)
				up_ena <= acc.data[0];
		end
	end

	always_ff @(posedge fclk)
	begin
		if (reg_wr && acc.data[7:6] == 2'b00)
			up_paladdr <= acc.data[5:0];
		if (data_wr)
			up_lastwritten <= acc.data;
	end

	assign up_palwr   = data_wr && state == UP_PALETTE;
	assign up_paldata = {acc.data[4:2], acc.data[7:5], acc.data[1:0]}; // G3R3B2 to R3G3B2

endmodule

`default_nettype wire

/* source/zports.sv */
/*
 * I/O port block top, all on fclk
 */
`default_nettype none

module zports (
	input  logic                fclk,
	input  logic                rst_n,
	input  logic [15:0]         addr,
	input  logic [7:0]          din,
	input  logic                iorq_n,
	input  logic                rd_n,
	input  logic                wr_n,
	input  logic                dos,
	input  logic [4:0]          keys_in,
	input  logic                tape_read,
	output logic [7:0]          dout,
	output logic                dataout,
	output logic                porthit,
	output logic                external_port,
	output zports_pkg::paging_t paging,
	output zports_pkg::config_t cfg,
	output logic [3:0]          border,
	output logic [15:0]         brk_addr,
	output logic                beeper_wr,
	output logic                covox_wr,
	output logic                clr_nmi,
	output logic                up_ena,
	output logic [5:0]          up_paladdr,
	output logic [7:0]          up_paldata,
	output logic                up_palwr
);
	import zports_pkg::*;

	logic         wr_stb;
	port_kind_e   port_kind;
	port_access_t acc;
	logic [7:0]   up_lastwritten;

	io_strobe_sync i_io_strobe_sync (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.wr_stb (wr_stb),
		.rd_stb () // no read side effects on kept ports
	);

	port_decoder i_port_decoder (
		.addr          (addr),
		.dos           (dos),
		.shadow_en     (cfg.shadow_en),
		.port_kind     (port_kind),
		.porthit       (porthit),
		.external_port (external_port)
	);

	assign acc = '{kind: port_kind, addr_hi: addr[15:8], lo_a3: addr[3], data: din, wr: wr_stb};

	paging_regs i_paging_regs (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.acc    (acc),
		.paging (paging)
	);

	config_regs i_config_regs (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.acc       (acc),
		.cfg       (cfg),
		.border    (border),
		.brk_addr  (brk_addr),
		.beeper_wr (beeper_wr),
		.covox_wr  (covox_wr),
		.clr_nmi   (clr_nmi)
	);

	ulaplus_ctrl i_ulaplus_ctrl (
		.fclk           (fclk),
		.rst_n          (rst_n),
		.acc            (acc),
		.up_ena         (up_ena),
		.up_paladdr     (up_paladdr),
		.up_paldata     (up_paldata),
		.up_palwr       (up_palwr),
		.up_lastwritten (up_lastwritten)
	);

	read_mux i_read_mux (
		.addr           (addr),
		.port_kind      (port_kind),
		.paging         (paging),
		.cfg            (cfg),
		.border         (border),
		.brk_addr       (brk_addr),
		.up_lastwritten (up_lastwritten),
		.keys_in        (keys_in),
		.tape_read      (tape_read),
		.dout           (dout)
	);

	// drive Z80 data bus only for our own reads
	assign dataout = porthit & ~iorq_n & ~rd_n & ~external_port;

endmodule

`default_nettype wire

/* source/zports_pkg.sv */
/*
 * zports shared definitions
 * port addresses, bd readback selectors, decoded port kinds and bus structs
 */
`default_nettype none

package zports_pkg;

	////////////////////////////////////////////////////////////
	// low address bytes of the ports handled here
	////////////////////////////////////////////////////////////
	localparam logic [7:0] PORT_FE = 8'hFE; // border, beeper, keyboard
	localparam logic [7:0] PORT_F6 = 8'hF6; // FE alias
	localparam logic [7:0] PORT_FC = 8'hFC; // FE alias, 7FFD alias with a15 low
	localparam logic [7:0] PORT_FD = 8'hFD; // 7FFD, AY ports when a15 high
	localparam logic [7:0] PORT_F7 = 8'hF7; // EFF7
	localparam logic [7:0] PORT_BF = 8'hBF; // config
	localparam logic [7:0] PORT_BE = 8'hBE; // readback, nmi end
	localparam logic [7:0] PORT_BD = 8'hBD; // readback, breakpoint write
	localparam logic [7:0] PORT_FB = 8'hFB; // covox
	localparam logic [7:0] PORT_3B = 8'h3B; // ULAplus

	// xxBD/xxBE selector, taken from a[12:8]
	typedef enum logic [4:0] {
		BD_P7FFD  = 5'h0A,
		BD_PEFF7  = 5'h0B,
		BD_BORDER = 5'h0F,
		BD_LOBRK  = 5'h10,
		BD_HIBRK  = 5'h11
	} bd_sel_e;

	// decoded port, shadow aliasing already resolved
	typedef enum logic [3:0] {
		PK_NONE,
		PK_FE,
		PK_F6FC,
		PK_7FFD,
		PK_EFF7,
		PK_BF,
		PK_BE,
		PK_BD,
		PK_COVOX,
		PK_UP_REG,
		PK_UP_DATA
	} port_kind_e;

	typedef enum logic {
		UP_PALETTE,
		UP_MODE
	} up_state_e;

	// one decoded I/O write as seen by the register blocks
	typedef struct packed {
		port_kind_e kind;
		logic [7:0] addr_hi; // a[15:8]
		logic       lo_a3;   // a[3], border bright bit
		logic [7:0] data;
		logic       wr;      // one fclk cycle
	} port_access_t;

	typedef struct packed {
		logic [7:0] p7ffd;      // effective, masked under block1m
		logic [7:0] peff7;      // effective
		logic [7:0] p7ffd_raw;  // as written, for readback
		logic [7:0] peff7_raw;
		logic [5:0] pent1m_page;
		logic       pent1m_rom;
		logic       pent1m_1m_on;
		logic       pent1m_ram0_0;
	} paging_t;

	// bit order matches xxBF data bits 5..0
	typedef struct packed {
		logic pal444_ena;
		logic brk_ena;
		logic set_nmi;
		logic fntw_en;
		logic romrw_en;
		logic shadow_en;
	} config_t;

endpackage

`default_nettype wire

/* testbench/zports_model.svh */
/*
 * reference model of the zports registers
 * expected register state, write rules, read values and paging outputs
 */
`ifndef ZPORTS_MODEL_SVH
`define ZPORTS_MODEL_SVH

logic [7:0]  m_p7ffd;   // as written
logic [7:0]  m_peff7;
logic [5:0]  m_cfg;     // xxBF bits 5..0
logic [3:0]  m_border;
logic [15:0] m_brk;
logic        m_up_mode; // ULAplus group, 1 for mode
logic        m_up_ena;
logic [7:0]  m_up_last;

function automatic void model_reset();
	m_p7ffd   = 8'h00;
	m_peff7   = 8'h00;
	m_cfg     = 6'h00;
	m_border  = 4'h0;
	m_brk     = 16'h0000;
	m_up_mode = 1'b0;
	m_up_ena  = 1'b0;
	m_up_last = 8'h00;
endfunction

// one I/O write as the Z80 issues it
function automatic void model_write(input logic [15:0] a, input logic [7:0] d,
	input logic dos_in);
	logic shadow;
	logic lock;
	shadow = dos_in | m_cfg[0];
	lock   = m_p7ffd[5] & m_peff7[2]; // 48k lock only with block1m
	case (a[7:0])
		8'hFE, 8'hF6:
			m_border = {~a[3], d[2:0]};
		8'hFC:
			if (a[15])
				m_border = {~a[3], d[2:0]}; // FE alias
			else if (!lock)
				m_p7ffd = d;
		8'hFD:
			if (!a[15] && !lock)
				m_p7ffd = d;
		8'hF7:
			if (!shadow && a[8] && !a[12])
				m_peff7 = d; // xEF7 shadow form is dropped
		8'hBF:
			m_cfg = d[5:0];
		8'hBD:
			if (a[12:8] == 5'h10)
				m_brk[7:0] = d;
			else if (a[12:8] == 5'h11)
				m_brk[15:8] = d;
		8'h3B:
			if (!a[14])
			begin
				if (d[7:6] == 2'b01)
					m_up_mode = 1'b1;
				else if (d[7:6] == 2'b00)
					m_up_mode = 1'b0;
			end
			else
			begin
				m_up_last = d;
				if (m_up_mode)
					m_up_ena = d[0];
			end
		default:
			;
	endcase
endfunction

function automatic logic [7:0] model_read(input logic [15:0] a, input logic [4:0] keys,
	input logic tape);
	case (a[7:0])
		8'hFE, 8'hF6:
			return {1'b1, tape, 1'b0, keys};
		8'hBF:
			return {2'b00, m_cfg};
		8'hBD, 8'hBE:
			case (a[12:8])
				5'h0A:   return m_p7ffd; // raw, never masked
				5'h0B:   return m_peff7;
				5'h0F:   return {4'h0, m_border};
				5'h10:   return m_brk[7:0];
				5'h11:   return m_brk[15:8];
				default: return 8'hFF;
			endcase
		8'h3B:
			return m_up_last;
		default:
			return 8'hFF; // FC and unclaimed ports float
	endcase
endfunction

// bus driven by us: own port hit, read active, not an AY port
function automatic logic model_dataout(input logic [15:0] a, input logic dos_in);
	case (a[7:0])
		8'hFE, 8'hF6, 8'hFC, 8'hBF, 8'hBE, 8'hBD, 8'h3B:
			return 1'b1;
		8'hFD:
			return !a[15]; // BFFD/FFFD are external
		8'hF7:
			return !(dos_in | m_cfg[0]);
		default:
			return 1'b0;
	endcase
endfunction

function automatic paging_t model_paging();
	paging_t p;
	logic    b1m;
	b1m             = m_peff7[2];
	p.p7ffd_raw     = m_p7ffd;
	p.peff7_raw     = m_peff7;
	p.p7ffd         = b1m ? {3'b000, m_p7ffd[4:0]} : m_p7ffd;
	p.peff7         = b1m ? {m_peff7[7], 1'b0, m_peff7[5:4], 3'b000, m_peff7[0]} : m_peff7;
	p.pent1m_page   = {m_p7ffd[7:5], m_p7ffd[2:0]};
	p.pent1m_rom    = m_p7ffd[4];
	p.pent1m_1m_on  = !b1m;
	p.pent1m_ram0_0 = m_peff7[3];
	return p;
endfunction

// G3R3B2 in, R3G3B2 out
function automatic logic [7:0] model_paldata(input logic [7:0] d);
	logic [2:0] g;
	logic [2:0] r;
	g = d[7:5];
	r = d[4:2];
	return {r, g, d[1:0]};
endfunction

`endif

/* testbench/tb_zports.sv */
/*
 * zports testbench
 * Z80 bus writes and reads compared with the reference model
 */
`default_nettype none

module tb_zports;
	import zports_pkg::*;

	localparam int ACCESS_COUNT = 80;                   // bound on accesses over all tests
	localparam int CYCLE_LIMIT  = 6 * ACCESS_COUNT + 64; // 6 cycles each plus reset

	logic        fclk;
	logic        rst_n;
	logic [15:0] addr;
	logic [7:0]  din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic        external_port;
	paging_t     paging;
	config_t     cfg;
	logic [3:0]  border;
	logic [15:0] brk_addr;
	logic        beeper_wr;
	logic        covox_wr;
	logic        clr_nmi;
	logic        up_ena;
	logic [5:0]  up_paladdr;
	logic [7:0]  up_paldata;
	logic        up_palwr;

	integer      seed;
	logic [31:0] rnd;
	int          cycles = 0;
	int          beep_cnt = 0;
	int          covox_cnt = 0;
	int          nmi_cnt = 0;
	int          palwr_cnt = 0;
	logic [7:0]  palwr_data; // up_paldata seen on the strobe
	int          checks;
	int          errors;
	int          test_errs;
	int          tests_run;
	int          tests_failed;
	int          fe_writes;
	int          beeps0;
	int          covox0;
	int          nmi0;
	int          pal0;
	string       cur_test;
	logic [7:0]  rd_data;    // sampled mid read
	logic        rd_oe;
	logic        rd_hit;
	logic        rd_ext;

	`include "zports_model.svh"

	zports i_zports (.*);

	initial fclk = 1'b0;
	always #10 fclk = ~fclk;

	// strobes are one cycle wide, so each shows at exactly one falling edge
	always @(negedge fclk)
	begin
		if (beeper_wr)
			beep_cnt <= beep_cnt + 1;
		if (covox_wr)
			covox_cnt <= covox_cnt + 1;
		if (clr_nmi)
			nmi_cnt <= nmi_cnt + 1;
		if (up_palwr)
		begin
			palwr_cnt  <= palwr_cnt + 1;
			palwr_data <= up_paldata;
		end
	end

	always @(posedge fclk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: tests still running after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// compare and bookkeeping
	////////////////////////////////////////////////////////////
	task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks = checks + 1;
		if (act !== exp)
		begin
			$display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
			test_errs = test_errs + 1;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run = tests_run + 1;
		errors    = errors + test_errs;
		if (test_errs == 0)
			$display("test %s: ok", cur_test);
		else
		begin
			tests_failed = tests_failed + 1;
			$display("test %s: %0d mismatches", cur_test, test_errs);
		end
	endtask

	task automatic check_regs();
		check("paging", 64'(model_paging()), 64'(paging));
		check("cfg", 64'(m_cfg), 64'(cfg));
		check("border", 64'(m_border), 64'(border));
		check("brk_addr", 64'(m_brk), 64'(brk_addr));
		check("up_ena", 64'(m_up_ena), 64'(up_ena));
	endtask

	////////////////////////////////////////////////////////////
	// Z80 bus cycles entered on a falling edge
	////////////////////////////////////////////////////////////
	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		addr   = a;
		din    = d;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		model_write(a, d, dos);
		repeat (4) @(negedge fclk); // held 4 cycles
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		repeat (2) @(negedge fclk); // idle
	endtask

	task automatic bus_read(input logic [15:0] a);
		addr   = a;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		repeat (2) @(negedge fclk);
		rd_data = dout; // combinational and settled mid cycle
		rd_oe   = dataout;
		rd_hit  = porthit;
		rd_ext  = external_port;
		repeat (2) @(negedge fclk);
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		repeat (2) @(negedge fclk);
	endtask

	task automatic read_check(input string what, input logic [15:0] a);
		bus_read(a);
		check(what, 64'(model_read(a, keys_in, tape_read)), 64'(rd_data));
		check({what, " dataout"}, 64'(model_dataout(a, dos)), 64'(rd_oe));
	endtask

	initial
	begin
		seed      = 32'h909162f9;
		rst_n     = 1'b0;
		addr      = 16'hFFFF;
		din       = 8'h00;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		keys_in   = 5'h1F; // no key pressed
		tape_read = 1'b0;
		checks       = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		model_reset();
		repeat (4) @(posedge fclk);
		@(negedge fclk);
		rst_n = 1'b1;
		@(negedge fclk);

		begin_test("reset");
		check_regs();
		read_check("bf read", 16'h00BF);
		read_check("7ffd readback", 16'h0ABD);
		end_test();

		begin_test("border_beeper");
		fe_writes = 0;
		beeps0    = beep_cnt;
		repeat (12)
		begin
			rnd = $random(seed);
			bus_write({rnd[15:8], (rnd[0] ? 8'hFE : 8'hF6)}, rnd[23:16]);
			if (rnd[0])
				fe_writes = fe_writes + 1;
			check_regs();
			read_check("border readback", 16'h0FBD);
		end
		covox0 = covox_cnt;
		nmi0   = nmi_cnt;
		bus_write(16'h00FB, rnd[7:0]); // covox sample
		bus_write(16'h00BE, 8'h00);    // nmi end
		check_regs();
		check("beeper pulses", 64'(fe_writes), 64'(beep_cnt - beeps0));
		check("covox pulses", 64'(1), 64'(covox_cnt - covox0));
		check("nmi clear pulses", 64'(1), 64'(nmi_cnt - nmi0));
		end_test();

		begin_test("paging_lock");
		bus_write(16'hEFF7, 8'h04); // block1m
		bus_write(16'h7FFD, 8'hE7); // lock bit set
		bus_write(16'h7FFD, 8'h10); // ignored while locked
		check_regs();
		repeat (17)
		begin
			rnd = $random(seed);
			bus_write(rnd[1] ? 16'hEFF7 : 16'h7FFD, rnd[15:8]);
			check_regs();
		end
		read_check("7ffd raw", 16'h0ABD);
		read_check("eff7 raw", 16'h0BBD);
		end_test();

		begin_test("shadow");
		bus_write(16'hEFF7, 8'h00);
		bus_write(16'h00BF, 8'h01); // shadow_en
		bus_write(16'hEFF7, 8'h5A); // must not land
		check_regs();
		check("peff7 kept", 64'(8'h00), 64'(paging.peff7_raw));
		bus_read(16'hEFF7);
		check("f7 porthit, shadow_en", 64'(0), 64'(rd_hit));
		bus_write(16'h00BF, 8'h00);
		dos = 1'b1;
		bus_write(16'hEFF7, 8'h3C);
		check_regs();
		bus_read(16'hEFF7);
		check("f7 porthit, dos", 64'(0), 64'(rd_hit));
		dos = 1'b0;
		bus_write(16'hEFF7, 8'h01); // lands again outside shadow
		check_regs();
		end_test();

		begin_test("bus_reads");
		rnd       = $random(seed);
		keys_in   = rnd[4:0];
		tape_read = rnd[5];
		read_check("fe read", {rnd[15:8], 8'hFE});
		read_check("f6 read", 16'h00F6);
		read_check("bf read", 16'h00BF);
		read_check("fb read", 16'h00FB); // covox is write only
		read_check("fffd read", 16'hFFFD);
		check("fffd external_port", 64'(1), 64'(rd_ext));
		check("idle dataout", 64'(0), 64'(dataout));
		bus_write(16'h10BD, rnd[23:16]);
		bus_write(16'h11BD, rnd[31:24]);
		check_regs();
		read_check("brk lo", 16'h10BD);
		read_check("brk hi", 16'h11BD);
		end_test();

		begin_test("ulaplus");
		pal0 = palwr_cnt;
		rnd  = $random(seed);
		bus_write(16'hBF3B, 8'h05); // palette group entry 5
		bus_write(16'hFF3B, rnd[7:0]);
		check("palwr pulses", 64'(1), 64'(palwr_cnt - pal0));
		check("paladdr", 64'(6'h05), 64'(up_paladdr));
		check("paldata", 64'(model_paldata(rnd[7:0])), 64'(palwr_data));
		bus_write(16'hBF3B, 8'h40); // mode group
		bus_write(16'hFF3B, 8'h01);
		check_regs();
		check("palwr in mode group", 64'(1), 64'(palwr_cnt - pal0));
		read_check("3b read", 16'hFF3B);
		end_test();

		$display("tests %0d, failed %0d, checks %0d, mismatches %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* zports.f */
+incdir+testbench
source/zports_pkg.sv
source/io_strobe_sync.sv
source/port_decoder.sv
source/paging_regs.sv
source/config_regs.sv
source/ulaplus_ctrl.sv
source/read_mux.sv
source/zports.sv
testbench/tb_zports.sv
